// ==== logic/bankSwap.sv ====
`timescale 1ns/100ps
`default_nettype none

module bankSwap import cachePkg::*; (
    input lineData evenLine,
    input lineData oddLine,
    input logic startOdd,
    output bankPair lines
);

    // The bank holding the start line leads, the other bank supplies the following line.
    assign lines.first = startOdd ? oddLine : evenLine;
    assign lines.next = startOdd ? evenLine : oddLine;

    // Once the banks return real data the select must be known too.
    always_comb begin
        if (!$isunknown({evenLine, oddLine})) begin
            assert (!$isunknown(startOdd))
            else $error("bankSwap: startOdd unknown while bank data is valid.");
        end
    end

endmodule

`default_nettype wire

// ==== logic/busPkg.sv ====
`default_nettype none

package busPkg;

    localparam int wbAddrWidth = 9;
    localparam int wbDataWidth = 64;

    typedef logic [wbDataWidth/8-1:0] wbSel;
    typedef logic [wbDataWidth-1:0] wbData;

    // Classic cycle, one transfer per cyc.
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [wbAddrWidth-1:0] adr;
        wbData dat;
        wbSel sel;
        logic tgaSigned;  // Address tag asking for a sign-extended load.
    } wbReq;

    typedef struct packed {
        wbData dat;
        logic ack;
    } wbResp;

endpackage

`default_nettype wire

// ==== logic/cachePkg.sv ====
`default_nettype none

package cachePkg;

    localparam int lineBytes = 16;
    localparam int bankLines = 16;

    // Offset in bits 3..0, bank parity in bit 4, line index in bits 8..5.
    typedef logic [8:0] byteAddr;

    typedef logic [$clog2(bankLines)-1:0] lineIdx;
    typedef logic [8*lineBytes-1:0] lineData;
    typedef logic [63:0] loadData;
    typedef logic [$clog2(lineBytes)-1:0] byteOffset;

    // Load width as a power of two bytes.
    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord,
        sizeDouble
    } loadSize;

    typedef struct packed {
        byteOffset offset;
        loadSize size;
        logic signExtend;
        logic startOdd;  // Start line sits in the odd bank.
    } alignReq;

    typedef struct packed {
        lineData first;  // Line that holds the start byte.
        lineData next;
    } bankPair;

endpackage

`default_nettype wire

// ==== logic/dualBankCache.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualBankCache import cachePkg::*, busPkg::*; (
    input logic clk,
    input logic rstN,
    input wbReq bus,
    output wbResp resp
);

    lineIdx evenIdx;
    lineIdx oddIdx;
    lineIdx wrIdx;
    logic evenWr;
    logic oddWr;
    logic wrHigh;
    wbData wrData;
    wbSel wrSel;
    lineData evenLine;
    lineData oddLine;
    bankPair pair;
    alignReq alignInfo;
    loadData aligned;

    loadController ctrl (
        .clk(clk),
        .rstN(rstN),
        .bus(bus),
        .resp(resp),
        .evenIdx(evenIdx),
        .oddIdx(oddIdx),
        .evenWr(evenWr),
        .oddWr(oddWr),
        .wrIdx(wrIdx),
        .wrHigh(wrHigh),
        .wrData(wrData),
        .wrSel(wrSel),
        .req(alignInfo),
        .aligned(aligned)
    );

    // Even-numbered lines.
    lineBank evenBank (
        .clk(clk),
        .rdIdx(evenIdx),
        .rdLine(evenLine),
        .wrEn(evenWr),
        .wrIdx(wrIdx),
        .wrHigh(wrHigh),
        .wrData(wrData),
        .wrSel(wrSel)
    );

    lineBank oddBank (
        .clk(clk),
        .rdIdx(oddIdx),
        .rdLine(oddLine),
        .wrEn(oddWr),
        .wrIdx(wrIdx),
        .wrHigh(wrHigh),
        .wrData(wrData),
        .wrSel(wrSel)
    );

    bankSwap swap (
        .evenLine(evenLine),
        .oddLine(oddLine),
        .startOdd(alignInfo.startOdd),
        .lines(pair)
    );

    outputAlign align (
        .lines(pair),
        .req(alignInfo),
        .data(aligned)
    );

endmodule

`default_nettype wire

// ==== logic/lineBank.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineBank import cachePkg::*, busPkg::*; (
    input logic clk,
    input lineIdx rdIdx,
    output lineData rdLine,
    input logic wrEn,
    input lineIdx wrIdx,
    input logic wrHigh,
    input wbData wrData,
    input wbSel wrSel
);

    lineData lines [bankLines];

    // Registered read, so data shows up one cycle after the index.
    always_ff @(posedge clk) begin
        rdLine <= lines[rdIdx];
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int i = 0; i < $bits(wbSel); i++) begin
                if (wrSel[i]) begin
                    lines[wrIdx][(wrHigh ? $bits(wbData) : 0) + i*8 +: 8] <= wrData[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/loadController.sv ====
`timescale 1ns/100ps
`default_nettype none

module loadController import cachePkg::*, busPkg::*; (
    input logic clk,
    input logic rstN,
    input wbReq bus,
    output wbResp resp,
    output lineIdx evenIdx,
    output lineIdx oddIdx,
    output logic evenWr,
    output logic oddWr,
    output lineIdx wrIdx,
    output logic wrHigh,
    output wbData wrData,
    output wbSel wrSel,
    output alignReq req,
    input loadData aligned
);

    typedef enum logic [1:0] {
        idle,
        read,
        respond,
        writeAck
    } ctrlState;

    ctrlState state;
    ctrlState nextState;
    byteAddr addr;
    lineIdx baseIdx;
    logic accept;
    loadSize selSize;
    logic selLegal;
    logic illegal;
    wbData respData;

    assign addr = bus.adr;
    assign baseIdx = addr[8:5];
    assign accept = (state == idle) && bus.cyc && bus.stb;

    // An odd start line is followed by the even line one index up. Line 31 wraps to 0.
    assign oddIdx = baseIdx;
    assign evenIdx = addr[4] ? baseIdx + 1'b1 : baseIdx;

    assign wrIdx = baseIdx;
    assign wrHigh = addr[3];  // Selects the half line.
    assign wrData = bus.dat;
    assign wrSel = bus.sel;
    assign evenWr = accept && bus.we && !addr[4];
    assign oddWr = accept && bus.we && addr[4];

    // Only contiguous low-byte selects are loads.
    always_comb begin
        selLegal = 1'b1;
        case (bus.sel)
            8'h01: selSize = sizeByte;
            8'h03: selSize = sizeHalf;
            8'h0f: selSize = sizeWord;
            8'hff: selSize = sizeDouble;
            default: begin
                selSize = sizeByte;
                selLegal = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        unique case (state)
            idle: begin
                if (accept) begin
                    nextState = bus.we ? writeAck : read;
                end
            end
            read: nextState = respond;  // Bank data is aligned this cycle.
            respond: nextState = idle;
            writeAck: nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            req <= '0;
            illegal <= 1'b0;
        end else begin
            state <= nextState;
            if (accept && !bus.we) begin
                req.offset <= addr[3:0];
                req.size <= selSize;
                req.signExtend <= bus.tgaSigned;
                req.startOdd <= addr[4];
                illegal <= !selLegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == read) begin
            respData <= illegal ? '0 : aligned;
        end
    end

    assign resp.dat = respData;
    assign resp.ack = (state == respond) || (state == writeAck);

    // The master holds its strobe until it sees the ack.
    ackInCycle: assert property (@(posedge clk) disable iff (!rstN)
        resp.ack |-> bus.cyc && bus.stb);

    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        resp.ack |=> !resp.ack);

    oneBankWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(evenWr && oddWr));

endmodule

`default_nettype wire

// ==== logic/outputAlign.sv ====
`timescale 1ns/100ps
`default_nettype none

module outputAlign import cachePkg::*; (
    input bankPair lines,
    input alignReq req,
    output loadData data
);

    logic [2*$bits(lineData)-1:0] doubled;
    lineData rotated;
    loadData merged;
    logic [4:0] sizeBytes;
    logic [4:0] endPos;
    logic crossing;
    logic fillBit;

    // Rotate right by the offset so the start byte lands in byte 0.
    assign doubled = {lines.first, lines.first} >> {req.offset, 3'b000};
    assign rotated = doubled[$bits(lineData)-1:0];

    assign sizeBytes = 5'd1 << req.size;
    assign endPos = {1'b0, req.offset} + sizeBytes;
    assign crossing = endPos > 5'(lineBytes);  // Load runs past the end of the first line.

    // Bytes past the line end come from the bottom of the next line, in order.
    always_comb begin
        merged = rotated[$bits(loadData)-1:0];
        for (int j = 0; j < $bits(loadData)/8; j++) begin
            if (crossing && (int'(req.offset) + j >= lineBytes)) begin
                merged[j*8 +: 8] = lines.next[(int'(req.offset) + j - lineBytes)*8 +: 8];
            end
        end
    end

    always_comb begin
        unique case (req.size)
            sizeByte: begin
                fillBit = req.signExtend & merged[7];
                data = {{56{fillBit}}, merged[7:0]};
            end
            sizeHalf: begin
                fillBit = req.signExtend & merged[15];
                data = {{48{fillBit}}, merged[15:0]};
            end
            sizeWord: begin
                fillBit = req.signExtend & merged[31];
                data = {{32{fillBit}}, merged[31:0]};
            end
            sizeDouble: begin
                fillBit = req.signExtend & merged[63];  // Nothing left to fill.
                data = merged;
            end
        endcase
    end

    always_comb begin
        assert (!$isunknown(req.size))
        else $error("outputAlign: load size unknown.");
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dualBankCacheTb -f src.f -o simv

# The log decides the result, so a simulation that stops early still gets checked.
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qxF "TESTS PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

// ==== src.f ====
logic/cachePkg.sv
logic/busPkg.sv
logic/lineBank.sv
logic/bankSwap.sv
logic/outputAlign.sv
logic/loadController.sv
logic/dualBankCache.sv
tb/tbClock.sv
tb/dualBankCacheTb.sv

// ==== tb/dualBankCacheTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualBankCacheTb
    import cachePkg::*, busPkg::*;
();

    localparam int memBytes = 512;
    localparam int writeCount = 67;  // Fill plus three directed writes.
    localparam int writeCycles = 2;
    localparam int loadCycles = 3;

    logic clk;
    logic rstN;
    wbReq bus;
    wbResp resp;

    logic [7:0] refMem [memBytes];
    int seed = 32'hc931;
    int cycles = 0;
    int cycleLimit = 0;

    string loadName [$];
    byteAddr loadAddr [$];
    wbSel loadSel [$];
    logic loadSigned [$];
    loadData loadExpect [$];

    tbClock clockGen (
        .clk(clk),
        .rstN(rstN)
    );

    dualBankCache dut (
        .clk(clk),
        .rstN(rstN),
        .bus(bus),
        .resp(resp)
    );

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic compareLoadData(input string name, input loadData expected,
                                   input loadData actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic verifyAck(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    // Byte-wise reference of the 512-byte space. The 9-bit sum wraps line 31 into line 0.
    function automatic loadData expectedLoad(input byteAddr addr, input wbSel sel,
                                             input logic signExt);
        loadData result;
        int count;
        byteAddr pos;
        result = '0;
        case (sel)
            8'h01: count = 1;
            8'h03: count = 2;
            8'h0f: count = 4;
            8'hff: count = 8;
            default: count = 0;  // No load size, so the answer is zero.
        endcase
        for (int k = 0; k < count; k++) begin
            pos = addr + byteAddr'(k);
            result[k*8 +: 8] = refMem[pos];
        end
        if (signExt && count > 0 && count < 8) begin
            if (result[count*8-1]) begin
                for (int k = count; k < 8; k++) begin
                    result[k*8 +: 8] = 8'hff;
                end
            end
        end
        return result;
    endfunction

    function automatic void updateMemory(input byteAddr addr, input wbData dat, input wbSel sel);
        byteAddr base;
        base = {addr[8:3], 3'b000};
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) begin
                refMem[base + byteAddr'(i)] = dat[i*8 +: 8];
            end
        end
    endfunction

    function automatic void addLoad(input string name, input byteAddr addr, input wbSel sel,
                                    input logic signExt);
        loadName.push_back(name);
        loadAddr.push_back(addr);
        loadSel.push_back(sel);
        loadSigned.push_back(signExt);
        loadExpect.push_back(loadData'(0));
    endfunction

    function automatic void buildTable();
        addLoad("alignByteEven", 9'h000, 8'h01, 1'b0);
        addLoad("alignHalfEven", 9'h022, 8'h03, 1'b0);
        addLoad("alignWordOdd", 9'h014, 8'h0f, 1'b0);
        addLoad("alignDoubleOdd", 9'h038, 8'hff, 1'b0);
        addLoad("alignDoubleEven", 9'h0c0, 8'hff, 1'b0);
        addLoad("alignByteOdd", 9'h1f5, 8'h01, 1'b0);
        addLoad("alignHalfOdd", 9'h03a, 8'h03, 1'b0);
        addLoad("alignWordEven", 9'h0a4, 8'h0f, 1'b0);
        for (int off = 0; off < 16; off++) begin
            addLoad($sformatf("inLineByte%0d", off), byteAddr'(9'h060 + off), 8'h01, 1'b0);
        end
        for (int off = 0; off <= 8; off++) begin
            addLoad($sformatf("inLineDouble%0d", off), byteAddr'(9'h090 + off), 8'hff, 1'b0);
        end
        addLoad("crossEvenToOdd", 9'h04c, 8'hff, 1'b0);
        addLoad("crossOddToEven", 9'h07e, 8'h0f, 1'b0);
        addLoad("crossHalf", 9'h03f, 8'h03, 1'b0);
        addLoad("wrapHalf", 9'h1ff, 8'h03, 1'b0);
        for (int off = 9; off < 16; off++) begin
            addLoad($sformatf("crossDouble%0d", off), byteAddr'(9'h0c0 + off), 8'hff, 1'b0);
            addLoad($sformatf("wrapDouble%0d", off), byteAddr'(9'h1f0 + off), 8'hff, 1'b0);
        end
        // The sign pattern holds bytes 98 ba dc fe 10 32 54 76 from address 100 hex up.
        addLoad("signByteSet", 9'h100, 8'h01, 1'b1);
        addLoad("signByteClear", 9'h104, 8'h01, 1'b1);
        addLoad("signHalfSet", 9'h102, 8'h03, 1'b1);
        addLoad("signHalfClear", 9'h106, 8'h03, 1'b1);
        addLoad("signWordSet", 9'h100, 8'h0f, 1'b1);
        addLoad("signWordClear", 9'h104, 8'h0f, 1'b1);
        addLoad("signDouble", 9'h100, 8'hff, 1'b1);
        addLoad("signWordCross", 9'h10e, 8'h0f, 1'b1);
        addLoad("partialHighDouble", 9'h058, 8'hff, 1'b0);
        addLoad("partialSpan", 9'h054, 8'hff, 1'b0);
        addLoad("partialCross", 9'h05c, 8'hff, 1'b0);
        addLoad("partialByteSigned", 9'h05b, 8'h01, 1'b1);
        addLoad("partialLowDouble", 9'h0e0, 8'hff, 1'b0);
        addLoad("partialLowCross", 9'h0de, 8'h0f, 1'b0);
        addLoad("illegalSel07", 9'h020, 8'h07, 1'b0);
        addLoad("illegalSel02", 9'h031, 8'h02, 1'b1);
        addLoad("illegalSel00", 9'h1c8, 8'h00, 1'b0);
    endfunction

    task automatic driveRequest(input logic we, input byteAddr addr, input wbData dat,
                                input wbSel sel, input logic signExt);
        bus.cyc = 1'b1;
        bus.stb = 1'b1;
        bus.we = we;
        bus.adr = addr;
        bus.dat = dat;
        bus.sel = sel;
        bus.tgaSigned = signExt;
    endtask

    task automatic releaseBus();
        bus.cyc = 1'b0;
        bus.stb = 1'b0;
        bus.we = 1'b0;
    endtask

    // Called 1 ns after a rising edge, which is the accepting cycle.
    task automatic writeDouble(input string name, input byteAddr addr, input wbData dat,
                               input wbSel sel);
        driveRequest(1'b1, addr, dat, sel, 1'b0);
        @(posedge clk);
        #1;
        verifyAck({name, " ack"}, 1'b1, resp.ack);
        @(posedge clk);
        #1;
        verifyAck({name, " second ack"}, 1'b0, resp.ack);
        updateMemory(addr, dat, sel);
        releaseBus();
    endtask

    task automatic issueLoad(input int idx);
        string name;
        name = loadName[idx];
        loadExpect[idx] = expectedLoad(loadAddr[idx], loadSel[idx], loadSigned[idx]);
        driveRequest(1'b0, loadAddr[idx], '0, loadSel[idx], loadSigned[idx]);
        @(posedge clk);
        #1;
        verifyAck({name, " early ack"}, 1'b0, resp.ack);
        @(posedge clk);
        #1;
        verifyAck({name, " ack"}, 1'b1, resp.ack);
        compareLoadData(name, loadExpect[idx], resp.dat);
        @(posedge clk);
        #1;
        verifyAck({name, " second ack"}, 1'b0, resp.ack);
        releaseBus();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: no result after %0d clock cycles.", cycleLimit);
            abortRun();
        end
    end

    initial begin
        logic [31:0] upper;
        logic [31:0] lower;
        bus = '0;
        buildTable();
        cycleLimit = 4 * (writeCount * writeCycles + loadName.size() * loadCycles) + 100;
        wait (rstN === 1'b1);
        @(posedge clk);
        #1;
        for (int d = 0; d < memBytes / 8; d++) begin
            upper = $random(seed);
            lower = $random(seed);
            writeDouble($sformatf("fill%0d", d), byteAddr'(d * 8), {upper, lower}, 8'hff);
        end
        writeDouble("signPattern", 9'h100, 64'h7654_3210_fedc_ba98, 8'hff);
        writeDouble("partialHigh", 9'h05b, 64'h1122_3344_5566_7788, 8'h5a);  // Bits 2..0 unused.
        writeDouble("partialLow", 9'h0e0, 64'h99aa_bbcc_ddee_ff00, 8'h81);
        for (int i = 0; i < loadName.size(); i++) begin
            issueLoad(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod = 5;
    localparam int resetCycles = 2;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Reset is released just after a rising edge.
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire
